// ==== project.f ====
+incdir+verilog
+incdir+verif
verilog/rv_decode_pkg.sv
verilog/rv_alu_decode.sv
verilog/rv_mem_flow_decode.sv
verilog/rv_ctrl_merge.sv
verilog/rv_decode_top.sv
verif/tb_rv_decode.sv

// ==== verif/tb_rv_decode_vectors.svh ====
// Each row holds name, instruction word, op A, op B, ALU code and memory bits
// Memory bits run mem_req mem_we mem_size gpr_we wb_src_sel branch jal jalr

localparam logic [9:0] no_mem    = 10'b00_000_00000;
localparam logic [9:0] wb_alu    = 10'b00_000_10000;
localparam logic [9:0] br_only   = 10'b00_000_00100;
localparam logic [9:0] link_jal  = 10'b00_000_10010;
localparam logic [9:0] link_jalr = 10'b00_000_10001;

task automatic load_table();
   // Register operands x1 <- x2 op x3 where the format has them
   add_row("add",   32'h003100B3, `RV_OPA_RS1,  `RV_OPB_RS2,   `RV_ALU_ADD,  wb_alu);
   add_row("sub",   32'h403100B3, `RV_OPA_RS1,  `RV_OPB_RS2,   `RV_ALU_SUB,  wb_alu);
   add_row("sll",   32'h003110B3, `RV_OPA_RS1,  `RV_OPB_RS2,   `RV_ALU_SLL,  wb_alu);
   add_row("slt",   32'h003120B3, `RV_OPA_RS1,  `RV_OPB_RS2,   `RV_ALU_SLTS, wb_alu);
   add_row("sltu",  32'h003130B3, `RV_OPA_RS1,  `RV_OPB_RS2,   `RV_ALU_SLTU, wb_alu);
   add_row("xor",   32'h003140B3, `RV_OPA_RS1,  `RV_OPB_RS2,   `RV_ALU_XOR,  wb_alu);
   add_row("srl",   32'h003150B3, `RV_OPA_RS1,  `RV_OPB_RS2,   `RV_ALU_SRL,  wb_alu);
   add_row("sra",   32'h403150B3, `RV_OPA_RS1,  `RV_OPB_RS2,   `RV_ALU_SRA,  wb_alu);
   add_row("or",    32'h003160B3, `RV_OPA_RS1,  `RV_OPB_RS2,   `RV_ALU_OR,   wb_alu);
   add_row("and",   32'h003170B3, `RV_OPA_RS1,  `RV_OPB_RS2,   `RV_ALU_AND,  wb_alu);
   add_row("addi",  32'hFFF10093, `RV_OPA_RS1,  `RV_OPB_IMM_I, `RV_ALU_ADD,  wb_alu);
   add_row("slti",  32'h00312093, `RV_OPA_RS1,  `RV_OPB_IMM_I, `RV_ALU_SLTS, wb_alu);
   add_row("sltiu", 32'h00313093, `RV_OPA_RS1,  `RV_OPB_IMM_I, `RV_ALU_SLTU, wb_alu);
   add_row("xori",  32'h80314093, `RV_OPA_RS1,  `RV_OPB_IMM_I, `RV_ALU_XOR,  wb_alu);
   add_row("ori",   32'h00316093, `RV_OPA_RS1,  `RV_OPB_IMM_I, `RV_ALU_OR,   wb_alu);
   add_row("andi",  32'h7FF17093, `RV_OPA_RS1,  `RV_OPB_IMM_I, `RV_ALU_AND,  wb_alu);
   add_row("slli",  32'h00311093, `RV_OPA_RS1,  `RV_OPB_IMM_I, `RV_ALU_SLL,  wb_alu);
   add_row("srli",  32'h00315093, `RV_OPA_RS1,  `RV_OPB_IMM_I, `RV_ALU_SRL,  wb_alu);
   add_row("srai",  32'h40315093, `RV_OPA_RS1,  `RV_OPB_IMM_I, `RV_ALU_SRA,  wb_alu);
   add_row("lui",   32'h123450B7, `RV_OPA_ZERO, `RV_OPB_IMM_U, `RV_ALU_ADD,  wb_alu);
   add_row("auipc", 32'h12345097, `RV_OPA_PC,   `RV_OPB_IMM_U, `RV_ALU_ADD,  wb_alu);
   // Loads and stores carry funct3 as the size
   add_row("lb",    32'h00310083, `RV_OPA_RS1,  `RV_OPB_IMM_I, `RV_ALU_ADD,  10'b10_000_11000);
   add_row("lw",    32'h00312083, `RV_OPA_RS1,  `RV_OPB_IMM_I, `RV_ALU_ADD,  10'b10_010_11000);
   add_row("lhu",   32'h00315083, `RV_OPA_RS1,  `RV_OPB_IMM_I, `RV_ALU_ADD,  10'b10_101_11000);
   add_row("sb",    32'h003100A3, `RV_OPA_RS1,  `RV_OPB_IMM_S, `RV_ALU_ADD,  10'b11_000_00000);
   add_row("sw",    32'h003120A3, `RV_OPA_RS1,  `RV_OPB_IMM_S, `RV_ALU_ADD,  10'b11_010_00000);
   add_row("beq",   32'h003100E3, `RV_OPA_RS1,  `RV_OPB_RS2,   `RV_ALU_EQ,   br_only);
   add_row("bne",   32'h003110E3, `RV_OPA_RS1,  `RV_OPB_RS2,   `RV_ALU_NE,   br_only);
   add_row("blt",   32'h003140E3, `RV_OPA_RS1,  `RV_OPB_RS2,   `RV_ALU_LTS,  br_only);
   add_row("bltu",  32'h003160E3, `RV_OPA_RS1,  `RV_OPB_RS2,   `RV_ALU_LTU,  br_only);
   add_row("bgeu",  32'h003170E3, `RV_OPA_RS1,  `RV_OPB_RS2,   `RV_ALU_GEU,  br_only);
   add_row("jal",   32'h008000EF, `RV_OPA_PC,   `RV_OPB_FOUR,  `RV_ALU_ADD,  link_jal);
   add_row("jalr",  32'h000100E7, `RV_OPA_PC,   `RV_OPB_FOUR,  `RV_ALU_ADD,  link_jalr);
   add_row("fence", 32'h0FF0000F, `RV_OPA_RS1,  `RV_OPB_RS2,   `RV_ALU_ADD,  no_mem);  // All zero
   // Illegal encodings
   add_illegal("quad01",   32'h003100B1);
   add_illegal("ecall",    32'h00000073);
   add_illegal("op_f7_01", 32'h023100B3);
   add_illegal("sll_alt",  32'h403110B3);
   add_illegal("slli_alt", 32'h40311093);
   add_illegal("ld_f3_3",  32'h00313083);
   add_illegal("st_f3_4",  32'h003140A3);
   add_illegal("br_f3_2",  32'h003120E3);
   add_illegal("jalr_f3",  32'h000110E7);
endtask

// ==== verif/tb_rv_decode.sv ====
`timescale 1ns/100ps

`include "rv_decode_macros.svh"

module tb_rv_decode
   import rv_decode_pkg::*;
();

   logic       clk;
   logic       rst_n;
   instr_t     instr;
   logic       in_valid;
   logic       in_ready;
   dec_ctrl_t  ctrl;
   logic       out_valid;
   logic       out_ready;

   string      name_tab[$];
   instr_t     instr_tab[$];
   dec_ctrl_t  exp_tab[$];
   int         txn_q[$];            // Accepted transactions in order
   int         accept_cyc_q[$];
   int         n_rows;
   int         accepted = 0;
   int         rows_done = 0;
   int         errors = 0;
   int         cycle = 0;
   int         limit = 0;
   logic       held_valid = 1'b0;
   dec_ctrl_t  held_ctrl;

   rv_decode_top u_dut (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .instr_i     (instr),
      .in_valid_i  (in_valid),
      .in_ready_o  (in_ready),
      .ctrl_o      (ctrl),
      .out_valid_o (out_valid),
      .out_ready_i (out_ready)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic add_row(input string name, input logic [31:0] word, input logic [1:0] opa,
                          input logic [2:0] opb, input logic [4:0] alu, input logic [9:0] mem);
      name_tab.push_back(name);
      instr_tab.push_back(instr_t'(word));
      exp_tab.push_back(dec_ctrl_t'({opa, opb, alu, mem, 1'b0}));
   endtask

   task automatic add_illegal(input string name, input logic [31:0] word);
      dec_ctrl_t exp_word;
      exp_word = '0;
      exp_word.illegal_instr = 1'b1;    // Nothing else may be set
      name_tab.push_back(name);
      instr_tab.push_back(instr_t'(word));
      exp_tab.push_back(exp_word);
   endtask

   `include "tb_rv_decode_vectors.svh"

   task automatic check_field(input string row, input string field,
                              input logic [7:0] act, input logic [7:0] exp);
      assert (act === exp) else begin
         $display("[FAIL] %s ctrl_o.%s expected 0x%0h got 0x%0h", row, field, exp, act);
         errors++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Output checker
   //////////////////////////////////////////////////////////////////////
   task automatic check_output();
      int     txn;
      int     idx;
      int     acc;
      int     err_before;
      string  row;
      assert (txn_q.size() > 0) else begin
         $display("Unexpected output word 0x%0h with no instruction pending", ctrl);
         errors++;
      end
      if (txn_q.size() > 0) begin
         txn = txn_q.pop_front();
         acc = accept_cyc_q.pop_front();
         idx = txn % n_rows;
         row = name_tab[idx];
         err_before = errors;
         check_field(row, "op_a_sel", ctrl.op_a_sel, exp_tab[idx].op_a_sel);
         check_field(row, "op_b_sel", ctrl.op_b_sel, exp_tab[idx].op_b_sel);
         check_field(row, "alu_op", ctrl.alu_op, exp_tab[idx].alu_op);
         check_field(row, "mem_req", ctrl.mem_req, exp_tab[idx].mem_req);
         check_field(row, "mem_we", ctrl.mem_we, exp_tab[idx].mem_we);
         check_field(row, "mem_size", ctrl.mem_size, exp_tab[idx].mem_size);
         check_field(row, "gpr_we", ctrl.gpr_we, exp_tab[idx].gpr_we);
         check_field(row, "wb_src_sel", ctrl.wb_src_sel, exp_tab[idx].wb_src_sel);
         check_field(row, "branch", ctrl.branch, exp_tab[idx].branch);
         check_field(row, "jal", ctrl.jal, exp_tab[idx].jal);
         check_field(row, "jalr", ctrl.jalr, exp_tab[idx].jalr);
         check_field(row, "illegal_instr", ctrl.illegal_instr, exp_tab[idx].illegal_instr);
         if (txn < n_rows) begin
            // First pass runs with out_ready held high
            assert (cycle == acc + 1) else begin
               $display("%s appeared %0d cycles after acceptance instead of 1", row, cycle - acc);
               errors++;
            end
         end
         rows_done++;
         $display("Row %0d %s %s", txn, row, (errors == err_before) ? "ok" : "failed");
      end
   endtask

   always @(posedge clk) begin
      cycle++;
      if (rst_n) begin
         if (accepted == 0) begin
            assert (!out_valid) else begin
               $display("[FAIL] out_valid_o expected 0x0 got 0x%0h before first accept",
                        out_valid);
               errors++;
            end
         end
         if (held_valid) begin
            assert (out_valid) else begin
               $display("Stalled output word was dropped before it was taken");
               errors++;
            end
            assert (ctrl === held_ctrl) else begin
               $display("[FAIL] ctrl_o expected 0x%0h got 0x%0h while stalled",
                        held_ctrl, ctrl);
               errors++;
            end
         end
         if (in_valid && accepted < n_rows) begin
            assert (in_ready) else begin
               $display("[FAIL] in_ready_o expected 0x1 got 0x%0h with out_ready_i high",
                        in_ready);
               errors++;
            end
         end
         held_valid = out_valid && !out_ready;
         held_ctrl  = ctrl;
         if (out_valid && out_ready) begin
            check_output();
         end
         if (in_valid && in_ready) begin
            txn_q.push_back(accepted);
            accept_cyc_q.push_back(cycle);
            accepted++;
         end
      end
      if (cycle > limit) begin
         $display("Timeout after %0d cycles, the decoder stopped making progress", limit);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Driver with free output first, then random back-pressure
   //////////////////////////////////////////////////////////////////////
   initial begin
      int pass;
      int row;
      void'($urandom(74969));
      rst_n     = 1'b0;
      instr     = '0;
      in_valid  = 1'b0;
      out_ready = 1'b0;
      load_table();
      n_rows = name_tab.size();
      limit  = 4 * (2 * n_rows) + 20;   // Two passes over the table
      repeat (4) @(posedge clk);
      rst_n     <= 1'b1;
      out_ready <= 1'b1;
      for (pass = 0; pass < 2; pass++) begin
         row = 0;
         while (row < n_rows) begin
            instr    <= instr_tab[row];
            in_valid <= 1'b1;
            if (pass == 1) begin
               out_ready <= ($urandom % 2) == 1;
            end
            @(posedge clk);
            if (in_ready) begin
               row++;
            end
         end
         in_valid  <= 1'b0;
         out_ready <= 1'b1;
         repeat (2) @(posedge clk);   // Drain before the next pass
      end
      assert (txn_q.size() == 0 && rows_done == 2 * n_rows) else begin
         $display("Missing output, %0d of %0d rows never appeared", 2 * n_rows - rows_done,
                  2 * n_rows);
         errors++;
      end
      $display("Done, %0d rows checked, %0d errors", rows_done, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// ==== verilog/rv_alu_decode.sv ====
`timescale 1ns/100ps

`include "rv_decode_macros.svh"

module rv_alu_decode
   import rv_decode_pkg::*;
(
   input  instr_t    instr_i,
   output ex_ctrl_t  ex_ctrl_o
);

   logic f7_base;
   logic f7_alt;

   assign f7_base = (instr_i.funct7 == `RV_F7_BASE);
   assign f7_alt  = (instr_i.funct7 == `RV_F7_ALT);

   // funct3 to ALU code when funct7 is zero
   function automatic logic [`RV_ALU_OP_W-1:0] base_op(input logic [2:0] funct3);
      logic [`RV_ALU_OP_W-1:0] op;
      case (funct3)
         3'b000:  op = `RV_ALU_ADD;
         3'b001:  op = `RV_ALU_SLL;
         3'b010:  op = `RV_ALU_SLTS;
         3'b011:  op = `RV_ALU_SLTU;
         3'b100:  op = `RV_ALU_XOR;
         3'b101:  op = `RV_ALU_SRL;
         3'b110:  op = `RV_ALU_OR;
         default: op = `RV_ALU_AND;
      endcase
      return op;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Opcode decode
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      ex_ctrl_o = '0;
      case (instr_i.opcode)
         `RV_OPC_OP: begin
            ex_ctrl_o.op_a_sel = `RV_OPA_RS1;
            ex_ctrl_o.op_b_sel = `RV_OPB_RS2;
            if (f7_base) begin
               ex_ctrl_o.alu_op = base_op(instr_i.funct3);
            end else if (f7_alt && instr_i.funct3 == 3'b000) begin
               ex_ctrl_o.alu_op = `RV_ALU_SUB;
            end else if (f7_alt && instr_i.funct3 == 3'b101) begin
               ex_ctrl_o.alu_op = `RV_ALU_SRA;
            end else begin
               ex_ctrl_o.ex_illegal = 1'b1;
            end
         end
         `RV_OPC_OP_IMM: begin
            ex_ctrl_o.op_a_sel = `RV_OPA_RS1;
            ex_ctrl_o.op_b_sel = `RV_OPB_IMM_I;
            ex_ctrl_o.alu_op   = base_op(instr_i.funct3);
            // Only the shifts carry funct7 in the immediate
            if (instr_i.funct3 == 3'b001 && !f7_base) begin
               ex_ctrl_o.ex_illegal = 1'b1;
            end else if (instr_i.funct3 == 3'b101) begin
               if (f7_alt) begin
                  ex_ctrl_o.alu_op = `RV_ALU_SRA;            // SRAI
               end else if (!f7_base) begin
                  ex_ctrl_o.ex_illegal = 1'b1;
               end
            end
         end
         `RV_OPC_LUI: begin
            ex_ctrl_o.op_a_sel = `RV_OPA_ZERO;              // 0 + imm
            ex_ctrl_o.op_b_sel = `RV_OPB_IMM_U;
         end
         `RV_OPC_AUIPC: begin
            ex_ctrl_o.op_a_sel = `RV_OPA_PC;
            ex_ctrl_o.op_b_sel = `RV_OPB_IMM_U;
         end
         `RV_OPC_LOAD: begin
            ex_ctrl_o.op_a_sel = `RV_OPA_RS1;               // Address = rs1 + imm
            ex_ctrl_o.op_b_sel = `RV_OPB_IMM_I;
         end
         `RV_OPC_STORE: begin
            ex_ctrl_o.op_a_sel = `RV_OPA_RS1;
            ex_ctrl_o.op_b_sel = `RV_OPB_IMM_S;
         end
         `RV_OPC_JAL, `RV_OPC_JALR: begin
            // Link value pc + 4, target built outside the ALU
            ex_ctrl_o.op_a_sel = `RV_OPA_PC;
            ex_ctrl_o.op_b_sel = `RV_OPB_FOUR;
         end
         `RV_OPC_BRANCH: begin
            ex_ctrl_o.op_a_sel = `RV_OPA_RS1;
            ex_ctrl_o.op_b_sel = `RV_OPB_RS2;
            case (instr_i.funct3)
               3'b000:  ex_ctrl_o.alu_op = `RV_ALU_EQ;
               3'b001:  ex_ctrl_o.alu_op = `RV_ALU_NE;
               3'b100:  ex_ctrl_o.alu_op = `RV_ALU_LTS;
               3'b101:  ex_ctrl_o.alu_op = `RV_ALU_GES;
               3'b110:  ex_ctrl_o.alu_op = `RV_ALU_LTU;
               3'b111:  ex_ctrl_o.alu_op = `RV_ALU_GEU;
               default: ex_ctrl_o.ex_illegal = 1'b1;   // 010, 011
            endcase
         end
         default: begin
            // FENCE and unknown opcodes, legality judged elsewhere
            ex_ctrl_o = '0;
         end
      endcase
   end

endmodule

// ==== verilog/rv_ctrl_merge.sv ====
`timescale 1ns/100ps

module rv_ctrl_merge
   import rv_decode_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_n_i,
   input  ex_ctrl_t   ex_ctrl_i,
   input  mem_ctrl_t  mem_ctrl_i,
   input  logic       in_valid_i,
   output logic       in_ready_o,
   output dec_ctrl_t  ctrl_o,
   output logic       out_valid_o,
   input  logic       out_ready_i
);

   logic       illegal;
   dec_ctrl_t  ctrl_d;
   dec_ctrl_t  ctrl_q;
   logic       valid_q;

   //////////////////////////////////////////////////////////////////////
   // Merge and illegal rule
   //////////////////////////////////////////////////////////////////////
   assign illegal = ex_ctrl_i.ex_illegal | mem_ctrl_i.flow_illegal;

   always_comb begin
      ctrl_d = '0;
      if (illegal) begin
         ctrl_d.illegal_instr = 1'b1;        // No side effects at all
      end else begin
         ctrl_d.op_a_sel   = ex_ctrl_i.op_a_sel;
         ctrl_d.op_b_sel   = ex_ctrl_i.op_b_sel;
         ctrl_d.alu_op     = ex_ctrl_i.alu_op;
         ctrl_d.mem_req    = mem_ctrl_i.mem_req;
         ctrl_d.mem_we     = mem_ctrl_i.mem_we;
         ctrl_d.mem_size   = mem_ctrl_i.mem_size;
         ctrl_d.gpr_we     = mem_ctrl_i.gpr_we;
         ctrl_d.wb_src_sel = mem_ctrl_i.wb_src_sel;
         ctrl_d.branch     = mem_ctrl_i.branch;
         ctrl_d.jal        = mem_ctrl_i.jal;
         ctrl_d.jalr       = mem_ctrl_i.jalr;
      end
   end

   // Output stage, accepts when empty or being drained
   assign in_ready_o = ~valid_q | out_ready_i;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         valid_q <= 1'b0;
      end else if (in_ready_o) begin
         valid_q <= in_valid_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (in_valid_i && in_ready_o) begin
         ctrl_q <= ctrl_d;
      end
   end

   assign ctrl_o      = ctrl_q;
   assign out_valid_o = valid_q;

endmodule

// ==== verilog/rv_decode_macros.svh ====
`ifndef RV_DECODE_MACROS_SVH
`define RV_DECODE_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Widths
//////////////////////////////////////////////////////////////////////
`define RV_XLEN         32
`define RV_OPC_W        5       // Major opcode, bits 6..2
`define RV_ALU_OP_W     5
`define RV_OPA_W        2
`define RV_OPB_W        3
`define RV_SIZE_W       3       // Same coding as load/store funct3

//////////////////////////////////////////////////////////////////////
// Major opcodes, quadrant bits stripped
//////////////////////////////////////////////////////////////////////
`define RV_OPC_LOAD     5'b00000
`define RV_OPC_FENCE    5'b00011
`define RV_OPC_OP_IMM   5'b00100
`define RV_OPC_AUIPC    5'b00101
`define RV_OPC_STORE    5'b01000
`define RV_OPC_OP       5'b01100
`define RV_OPC_LUI      5'b01101
`define RV_OPC_BRANCH   5'b11000
`define RV_OPC_JALR     5'b11001
`define RV_OPC_JAL      5'b11011

// ALU operation codes
`define RV_ALU_ADD      5'b00000
`define RV_ALU_SLL      5'b00001
`define RV_ALU_SLTS     5'b00010
`define RV_ALU_SLTU     5'b00011
`define RV_ALU_XOR      5'b00100
`define RV_ALU_SRL      5'b00101
`define RV_ALU_OR       5'b00110
`define RV_ALU_AND      5'b00111
`define RV_ALU_SUB      5'b01000
`define RV_ALU_SRA      5'b01101
`define RV_ALU_EQ       5'b11000
`define RV_ALU_NE       5'b11001
`define RV_ALU_LTS      5'b11100
`define RV_ALU_GES      5'b11101
`define RV_ALU_LTU      5'b11110
`define RV_ALU_GEU      5'b11111

// Operand selects
`define RV_OPA_RS1      2'd0
`define RV_OPA_PC       2'd1
`define RV_OPA_ZERO     2'd2

`define RV_OPB_RS2      3'd0
`define RV_OPB_IMM_I    3'd1
`define RV_OPB_IMM_U    3'd2
`define RV_OPB_IMM_S    3'd3
`define RV_OPB_FOUR     3'd4

`define RV_F7_BASE      7'b0000000
`define RV_F7_ALT       7'b0100000  // SUB, SRA, SRAI

`endif

// ==== verilog/rv_decode_pkg.sv ====
`include "rv_decode_macros.svh"

package rv_decode_pkg;

   //////////////////////////////////////////////////////////////////////
   // Raw instruction, R-type field layout
   //////////////////////////////////////////////////////////////////////
   typedef struct packed {
      logic [6:0]             funct7;
      logic [4:0]             rs2;
      logic [4:0]             rs1;
      logic [2:0]             funct3;
      logic [4:0]             rd;
      logic [`RV_OPC_W-1:0]   opcode;
      logic [1:0]             quadrant;   // 2'b11 for 32-bit encodings
   } instr_t;

   // Execute decoder result
   typedef struct packed {
      logic [`RV_OPA_W-1:0]     op_a_sel;
      logic [`RV_OPB_W-1:0]     op_b_sel;
      logic [`RV_ALU_OP_W-1:0]  alu_op;
      logic                     ex_illegal;
   } ex_ctrl_t;

   // Memory and flow decoder result
   typedef struct packed {
      logic                   mem_req;
      logic                   mem_we;
      logic [`RV_SIZE_W-1:0]  mem_size;
      logic                   gpr_we;
      logic                   wb_src_sel;   // 1 selects load data
      logic                   branch;
      logic                   jal;
      logic                   jalr;
      logic                   flow_illegal;
   } mem_ctrl_t;

   // Merged word seen by the pipeline
   typedef struct packed {
      logic [`RV_OPA_W-1:0]     op_a_sel;
      logic [`RV_OPB_W-1:0]     op_b_sel;
      logic [`RV_ALU_OP_W-1:0]  alu_op;
      logic                     mem_req;
      logic                     mem_we;
      logic [`RV_SIZE_W-1:0]    mem_size;
      logic                     gpr_we;
      logic                     wb_src_sel;
      logic                     branch;
      logic                     jal;
      logic                     jalr;
      logic                     illegal_instr;
   } dec_ctrl_t;

endpackage

// ==== verilog/rv_decode_top.sv ====
`timescale 1ns/100ps

module rv_decode_top
   import rv_decode_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_n_i,
   input  instr_t     instr_i,
   input  logic       in_valid_i,
   output logic       in_ready_o,
   output dec_ctrl_t  ctrl_o,
   output logic       out_valid_o,
   input  logic       out_ready_i
);

   ex_ctrl_t   ex_ctrl;
   mem_ctrl_t  mem_ctrl;

   // Both decoders see the same word in parallel
   rv_alu_decode u_alu_decode (
      .instr_i     (instr_i),
      .ex_ctrl_o   (ex_ctrl)
   );

   rv_mem_flow_decode u_mem_flow_decode (
      .instr_i     (instr_i),
      .mem_ctrl_o  (mem_ctrl)
   );

   rv_ctrl_merge u_ctrl_merge (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .ex_ctrl_i   (ex_ctrl),
      .mem_ctrl_i  (mem_ctrl),
      .in_valid_i  (in_valid_i),
      .in_ready_o  (in_ready_o),
      .ctrl_o      (ctrl_o),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i)
   );

endmodule

// ==== verilog/rv_mem_flow_decode.sv ====
`timescale 1ns/100ps

`include "rv_decode_macros.svh"

module rv_mem_flow_decode
   import rv_decode_pkg::*;
(
   input  instr_t     instr_i,
   output mem_ctrl_t  mem_ctrl_o
);

   logic load_size_ok;
   logic store_size_ok;

   // LB LH LW LBU LHU
   assign load_size_ok = (instr_i.funct3 == 3'b000) || (instr_i.funct3 == 3'b001) ||
                         (instr_i.funct3 == 3'b010) || (instr_i.funct3 == 3'b100) ||
                         (instr_i.funct3 == 3'b101);

   // SB SH SW
   assign store_size_ok = (instr_i.funct3 == 3'b000) || (instr_i.funct3 == 3'b001) ||
                          (instr_i.funct3 == 3'b010);

   //////////////////////////////////////////////////////////////////////
   // Memory, write-back and flow controls
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      mem_ctrl_o = '0;
      if (instr_i.quadrant != 2'b11) begin
         mem_ctrl_o.flow_illegal = 1'b1;        // Compressed space not supported
      end else begin
         case (instr_i.opcode)
            `RV_OPC_LOAD: begin
               if (load_size_ok) begin
                  mem_ctrl_o.mem_req    = 1'b1;
                  mem_ctrl_o.mem_size   = instr_i.funct3;
                  mem_ctrl_o.gpr_we     = 1'b1;
                  mem_ctrl_o.wb_src_sel = 1'b1;   // Write back load data
               end else begin
                  mem_ctrl_o.flow_illegal = 1'b1;
               end
            end
            `RV_OPC_STORE: begin
               if (store_size_ok) begin
                  mem_ctrl_o.mem_req  = 1'b1;
                  mem_ctrl_o.mem_we   = 1'b1;
                  mem_ctrl_o.mem_size = instr_i.funct3;
               end else begin
                  mem_ctrl_o.flow_illegal = 1'b1;
               end
            end
            `RV_OPC_OP, `RV_OPC_OP_IMM, `RV_OPC_LUI, `RV_OPC_AUIPC: begin
               mem_ctrl_o.gpr_we = 1'b1;
            end
            `RV_OPC_JAL: begin
               mem_ctrl_o.gpr_we = 1'b1;
               mem_ctrl_o.jal    = 1'b1;
            end
            `RV_OPC_JALR: begin
               if (instr_i.funct3 == 3'b000) begin
                  mem_ctrl_o.gpr_we = 1'b1;
                  mem_ctrl_o.jalr   = 1'b1;
               end else begin
                  mem_ctrl_o.flow_illegal = 1'b1;
               end
            end
            `RV_OPC_BRANCH: begin
               mem_ctrl_o.branch = 1'b1;        // Compare code from ALU side
            end
            `RV_OPC_FENCE: begin
               // Legal no-op
               mem_ctrl_o = '0;
            end
            default: begin
               mem_ctrl_o.flow_illegal = 1'b1;  // SYSTEM and unknown
            end
         endcase
      end
   end

endmodule
